/* include/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

`define CORE_XLEN  32             // data and address width
`define IMEM_DEPTH 256            // instruction words in the store
`define RESET_PC   32'h0000_0000  // first fetch address

`endif

/* hw/isaPkg.sv */
package isaPkg;

    typedef enum logic [6:0] {
        opcOp     = 7'b0110011,  // reg-reg alu
        opcOpImm  = 7'b0010011,  // reg-imm alu
        opcBranch = 7'b1100011,  // conditional branches
        opcJal    = 7'b1101111   // jump and link
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSll,
        aluSlt  // signed compare
    } aluOpT;

    typedef enum logic [1:0] {
        immNone,  // no immediate used
        immI,
        immB,
        immJ
    } immFmtT;

    typedef enum logic [1:0] {
        brNone,
        brBeq,
        brBlt,
        brJal  // always taken
    } branchKindT;

    typedef logic [4:0] regIdxT;

    localparam logic [2:0] f3AddSub = 3'b000;  // add, sub, addi
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Blt    = 3'b100;

    localparam logic [6:0] f7Base   = 7'b0000000;
    localparam logic [6:0] f7Alt    = 7'b0100000;  // sub

endpackage

/* hw/pipePkg.sv */
`include "core_params.svh"

package pipePkg;

    localparam int ImemAddrW = $clog2(`IMEM_DEPTH);  // word address bits

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        logic [31:0]           instruction;
    } fetchDecodeT;  // 64 bits

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        isaPkg::regIdxT        rs1;
        isaPkg::regIdxT        rs2;
        logic [`CORE_XLEN-1:0] rs1Value;   // read in decode, may be stale
        logic [`CORE_XLEN-1:0] rs2Value;
        logic [`CORE_XLEN-1:0] immediate;  // already sign extended
        isaPkg::aluOpT         aluOp;
        logic                  useImm;     // alu b from immediate
        isaPkg::branchKindT    branchKind;
        isaPkg::regIdxT        rd;         // zero when no write
        logic                  writeEn;
    } decodeExecT;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        isaPkg::regIdxT        rd;
        logic                  writeEn;
        logic [`CORE_XLEN-1:0] value;
    } execResultT;  // also the forwarding record

    typedef struct packed {
        logic                  taken;
        logic [`CORE_XLEN-1:0] target;
    } redirectT;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        isaPkg::regIdxT        rd;  // 0 when nothing written
        logic [`CORE_XLEN-1:0] value;
    } retireT;

    typedef struct packed {
        logic                 writeEn;
        logic [ImemAddrW-1:0] addr;  // word address
        logic [31:0]          data;
    } progLoadT;

endpackage

/* hw/instructionMemory.sv */
`timescale 1ns/10ps
`include "core_params.svh"

module instructionMemory (
    input  logic                  clk,
    input  logic [`CORE_XLEN-1:0] pc,
    input  pipePkg::progLoadT     prog,
    output logic [31:0]           instruction
);
    import pipePkg::*;

    logic [31:0]          store [`IMEM_DEPTH];  // program words, no reset
    logic [ImemAddrW-1:0] wordAddr;

    assign wordAddr = pc[2 +: ImemAddrW];  // byte pc -> word index

    always_ff @(posedge clk) begin
        if (prog.writeEn) begin
            store[prog.addr] <= prog.data;  // load port
        end
    end

    assign instruction = store[wordAddr];  // async read

endmodule

/* hw/stageReg.sv */
`timescale 1ns/10ps

module stageReg #(
    parameter type payloadT = pipePkg::fetchDecodeT
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    flush,     // squash what is captured this edge
    input  logic    inValid,
    input  payloadT inData,
    output logic    outValid,
    output payloadT outData
);
    import pipePkg::*;

    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            outValid <= 1'b0;  // bubble
        end else begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        outData <= inData;  // payload moves every cycle, valid qualifies it
    end

endmodule

/* hw/fetchStage.sv */
`timescale 1ns/10ps
`include "core_params.svh"

module fetchStage (
    input  logic                 clk,
    input  logic                 rstN,
    input  pipePkg::progLoadT    prog,
    input  pipePkg::redirectT    redirect,
    output logic                 fetchValid,
    output pipePkg::fetchDecodeT fetch
);
    import pipePkg::*;

    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] pcNext;
    logic [31:0]           instr;
    progLoadT              progGated;

    always_comb begin
        progGated         = prog;
        progGated.writeEn = prog.writeEn & ~rstN;  // loading only while in reset
    end

    assign pcNext = redirect.taken ? redirect.target : pc + `CORE_XLEN'd4;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pcNext;  // step or jump
        end
    end

    instructionMemory imem0 (
        .clk         (clk),
        .pc          (pc),
        .prog        (progGated),
        .instruction (instr)
    );

    assign fetchValid        = rstN;  // nothing real comes out during reset
    assign fetch.pc          = pc;
    assign fetch.instruction = instr;

endmodule

/* hw/decodeStage.sv */
`timescale 1ns/10ps
`include "core_params.svh"

module decodeStage (
    input  pipePkg::fetchDecodeT  fd,
    output isaPkg::regIdxT        rs1,
    output isaPkg::regIdxT        rs2,
    input  logic [`CORE_XLEN-1:0] rs1Value,
    input  logic [`CORE_XLEN-1:0] rs2Value,
    output pipePkg::decodeExecT   de
);
    import isaPkg::*;
    import pipePkg::*;

    logic [31:0]           instr;
    opcodeT                opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    regIdxT                rd;
    logic [`CORE_XLEN-1:0] immIVal;
    logic [`CORE_XLEN-1:0] immBVal;
    logic [`CORE_XLEN-1:0] immJVal;
    immFmtT                immFmt;
    aluOpT                 aluOp;
    branchKindT            branchKind;
    logic                  useImm;
    logic                  writesRd;  // encoding writes rd, before x0 check

    assign instr  = fd.instruction;
    assign opcode = opcodeT'(instr[6:0]);  // unknown codes fall to default
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];  // read every cycle, unused ones are harmless
    assign rs2    = instr[24:20];

    // sign extended immediates
    assign immIVal = {{(`CORE_XLEN-12){instr[31]}}, instr[31:20]};
    assign immBVal = {{(`CORE_XLEN-13){instr[31]}}, instr[31], instr[7],
                      instr[30:25], instr[11:8], 1'b0};
    assign immJVal = {{(`CORE_XLEN-21){instr[31]}}, instr[31], instr[19:12],
                      instr[20], instr[30:21], 1'b0};

    always_comb begin
        aluOp      = aluAdd;  // defaults give a no-op
        useImm     = 1'b0;
        branchKind = brNone;
        writesRd   = 1'b0;
        immFmt     = immNone;
        case (opcode)
            opcOpImm: begin
                immFmt   = immI;
                useImm   = 1'b1;
                writesRd = 1'b1;
                case (funct3)
                    f3AddSub: aluOp = aluAdd;  // addi
                    f3Slt:    aluOp = aluSlt;  // slti
                    f3And:    aluOp = aluAnd;  // andi
                    f3Sll: begin
                        aluOp    = aluSll;  // slli, shamt in imm[4:0]
                        writesRd = (funct7 == f7Base);
                    end
                    default:  writesRd = 1'b0;  // ori, xori, shifts right
                endcase
            end
            opcOp: begin
                writesRd = 1'b1;
                case ({funct7, funct3})
                    {f7Base, f3AddSub}: aluOp = aluAdd;
                    {f7Alt,  f3AddSub}: aluOp = aluSub;
                    {f7Base, f3And}:    aluOp = aluAnd;
                    {f7Base, f3Or}:     aluOp = aluOr;
                    {f7Base, f3Sll}:    aluOp = aluSll;
                    {f7Base, f3Slt}:    aluOp = aluSlt;
                    default:            writesRd = 1'b0;
                endcase
            end
            opcBranch: begin
                immFmt = immB;
                case (funct3)
                    f3Beq:   branchKind = brBeq;
                    f3Blt:   branchKind = brBlt;
                    default: branchKind = brNone;  // bne, bge... no-op
                endcase
            end
            opcJal: begin
                immFmt     = immJ;
                branchKind = brJal;
                writesRd   = 1'b1;  // link value
            end
            default: ;  // unsupported, retires as no-op
        endcase
    end

    always_comb begin
        de.pc         = fd.pc;
        de.rs1        = rs1;
        de.rs2        = rs2;
        de.rs1Value   = rs1Value;
        de.rs2Value   = rs2Value;
        case (immFmt)
            immI:    de.immediate = immIVal;
            immB:    de.immediate = immBVal;
            immJ:    de.immediate = immJVal;
            default: de.immediate = '0;
        endcase
        de.aluOp      = aluOp;
        de.useImm     = useImm;
        de.branchKind = branchKind;
        de.writeEn    = writesRd && (rd != '0);  // x0 never written
        de.rd         = de.writeEn ? rd : '0;
    end

endmodule

/* hw/executeStage.sv */
`timescale 1ns/10ps
`include "core_params.svh"

module executeStage (
    input  logic                deValid,
    input  pipePkg::decodeExecT de,
    input  pipePkg::execResultT fwd,
    input  logic                fwdValid,
    output logic                erValid,
    output pipePkg::execResultT er,
    output pipePkg::redirectT   redirect
);
    import isaPkg::*;
    import pipePkg::*;

    logic                  fwdHit;  // result stage holds a usable write
    logic [`CORE_XLEN-1:0] opA;
    logic [`CORE_XLEN-1:0] opB;
    logic [`CORE_XLEN-1:0] aluB;
    logic [`CORE_XLEN-1:0] aluRes;
    logic                  taken;

    assign fwdHit = fwdValid && fwd.writeEn && (fwd.rd != '0);

    // bypass the older instruction in result stage
    assign opA  = (fwdHit && fwd.rd == de.rs1) ? fwd.value : de.rs1Value;
    assign opB  = (fwdHit && fwd.rd == de.rs2) ? fwd.value : de.rs2Value;
    assign aluB = de.useImm ? de.immediate : opB;

    always_comb begin
        case (de.aluOp)
            aluAdd:  aluRes = opA + aluB;
            aluSub:  aluRes = opA - aluB;
            aluAnd:  aluRes = opA & aluB;
            aluOr:   aluRes = opA | aluB;
            aluSll:  aluRes = opA << aluB[4:0];  // 5-bit shamt
            aluSlt:  aluRes = {{(`CORE_XLEN-1){1'b0}}, $signed(opA) < $signed(aluB)};
            default: aluRes = '0;
        endcase
    end

    always_comb begin
        case (de.branchKind)
            brBeq:   taken = (opA == opB);
            brBlt:   taken = ($signed(opA) < $signed(opB));
            brJal:   taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect.taken  = deValid && taken;  // bubbles never redirect
    assign redirect.target = de.pc + de.immediate;

    assign erValid    = deValid;
    assign er.pc      = de.pc;
    assign er.rd      = de.rd;
    assign er.writeEn = de.writeEn;
    assign er.value   = (de.branchKind == brJal) ? de.pc + `CORE_XLEN'd4 : aluRes;

endmodule

/* hw/resultStage.sv */
`timescale 1ns/10ps
`include "core_params.svh"

module resultStage (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  erValid,
    input  pipePkg::execResultT   er,
    input  isaPkg::regIdxT        rs1,
    input  isaPkg::regIdxT        rs2,
    output logic [`CORE_XLEN-1:0] rs1Value,
    output logic [`CORE_XLEN-1:0] rs2Value,
    output pipePkg::execResultT   fwd,
    output logic                  fwdValid,
    output logic                  retireValid,
    output pipePkg::retireT       retire
);
    import isaPkg::*;
    import pipePkg::*;

    logic [`CORE_XLEN-1:0] regs [1:31];  // x0 is not stored
    logic                  doWrite;

    assign doWrite = erValid && er.writeEn && (er.rd != '0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;  // architectural state starts at zero
            end
        end else if (doWrite) begin
            regs[er.rd] <= er.value;
        end
    end

    // write-through read so decode sees this cycle's write
    function automatic logic [`CORE_XLEN-1:0] readReg(input regIdxT idx);
        if (idx == '0) begin
            return '0;
        end
        if (doWrite && er.rd == idx) begin
            return er.value;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1Value = readReg(rs1);
        rs2Value = readReg(rs2);
    end

    assign fwd      = er;  // held record doubles as bypass source
    assign fwdValid = erValid;

    assign retireValid  = erValid;
    assign retire.pc    = er.pc;
    assign retire.rd    = er.writeEn ? er.rd : '0;
    assign retire.value = er.writeEn ? er.value : '0;  // no-ops report zero

endmodule

/* hw/riscvCore.sv */
`timescale 1ns/10ps
`include "core_params.svh"

module riscvCore (
    input  logic              clk,
    input  logic              rstN,
    input  pipePkg::progLoadT prog,
    output logic              retireValid,
    output pipePkg::retireT   retire
);
    import isaPkg::*;
    import pipePkg::*;

    logic                  fetchValid;
    fetchDecodeT           fetch;
    logic                  fdValid;
    fetchDecodeT           fdData;
    regIdxT                rs1;
    regIdxT                rs2;
    logic [`CORE_XLEN-1:0] rs1Value;
    logic [`CORE_XLEN-1:0] rs2Value;
    decodeExecT            deIn;
    logic                  deValid;
    decodeExecT            deData;
    logic                  exValid;
    execResultT            exOut;
    logic                  erValid;
    execResultT            erData;
    execResultT            fwd;
    logic                  fwdValid;
    redirectT              redirect;

    fetchStage fetch0 (
        .clk        (clk),
        .rstN       (rstN),
        .prog       (prog),
        .redirect   (redirect),
        .fetchValid (fetchValid),
        .fetch      (fetch)
    );

    stageReg #(.payloadT(fetchDecodeT)) fdReg (
        .clk      (clk),
        .rstN     (rstN),
        .flush    (redirect.taken),  // younger of the two in the shadow
        .inValid  (fetchValid),
        .inData   (fetch),
        .outValid (fdValid),
        .outData  (fdData)
    );

    decodeStage decode0 (
        .fd       (fdData),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1Value (rs1Value),
        .rs2Value (rs2Value),
        .de       (deIn)
    );

    stageReg #(.payloadT(decodeExecT)) deReg (
        .clk      (clk),
        .rstN     (rstN),
        .flush    (redirect.taken),
        .inValid  (fdValid),
        .inData   (deIn),
        .outValid (deValid),
        .outData  (deData)
    );

    executeStage execute0 (
        .deValid  (deValid),
        .de       (deData),
        .fwd      (fwd),
        .fwdValid (fwdValid),
        .erValid  (exValid),
        .er       (exOut),
        .redirect (redirect)
    );

    stageReg #(.payloadT(execResultT)) erReg (
        .clk      (clk),
        .rstN     (rstN),
        .flush    (1'b0),  // branch itself always retires
        .inValid  (exValid),
        .inData   (exOut),
        .outValid (erValid),
        .outData  (erData)
    );

    resultStage result0 (
        .clk         (clk),
        .rstN        (rstN),
        .erValid     (erValid),
        .er          (erData),
        .rs1         (rs1),
        .rs2         (rs2),
        .rs1Value    (rs1Value),
        .rs2Value    (rs2Value),
        .fwd         (fwd),
        .fwdValid    (fwdValid),
        .retireValid (retireValid),
        .retire      (retire)
    );

endmodule

/* verification/tbRiscvCore.sv */
`timescale 1ns/10ps
`include "core_params.svh"

module tbRiscvCore;
    import pipePkg::*;

    localparam int ProgWords     = 64;                 // random part of the program
    localparam int HaltPc        = ProgWords * 4;      // jal x0,0 sits right after it
    localparam int RetireTimeout = 16;                 // cycles without a retire
    localparam int MaxRetires    = 200;                // forward-only code ends far sooner

    logic                  clk;
    logic                  rstN;
    progLoadT              prog;
    logic                  retireValid;
    retireT                retire;

    logic [15:0]           lfsr;                       // random source
    logic [31:0]           progImage [ProgWords + 1];  // words 0..64
    logic [`CORE_XLEN-1:0] modelRegs [32];             // architectural registers
    logic [`CORE_XLEN-1:0] modelPc;

    riscvCore dut0 (
        .clk         (clk),
        .rstN        (rstN),
        .prog        (prog),
        .retireValid (retireValid),
        .retire      (retire)
    );

    always #5 clk = ~clk;  // 10 ns period

    // taps of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        int          k;
        r = '0;
        for (k = 0; k < n; k++) begin
            lfsr = lfsrNext(lfsr);
            r    = {r[30:0], lfsr[0]};  // newest bit at the bottom
        end
        return r;
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic genProgram();
        logic [3:0]  sel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        int          off;
        int          i;
        for (i = 0; i < ProgWords; i++) begin
            sel = 4'(randBits(4));
            rd  = 5'(randBits(3));  // x0..x7 only for lots of reuse
            rs1 = 5'(randBits(3));
            rs2 = 5'(randBits(3));
            imm = 12'(randBits(12));
            off = 1 + randBits(2);  // forward 1..4 words
            if (i + off > ProgWords) begin
                off = ProgWords - i;  // at most onto the halt word
            end
            case (sel)
                0, 14: progImage[i] = encI(imm, rs1, 3'd0, rd, 7'b0010011);  // addi
                1:     progImage[i] = encI({7'd0, 5'(randBits(5))}, rs1, 3'd1, rd, 7'b0010011);
                2:     progImage[i] = encI(imm, rs1, 3'd2, rd, 7'b0010011);  // slti
                3:     progImage[i] = encI(imm, rs1, 3'd7, rd, 7'b0010011);  // andi
                4, 15: progImage[i] = encR(7'h00, rs2, rs1, 3'd0, rd);       // add
                5:     progImage[i] = encR(7'h20, rs2, rs1, 3'd0, rd);       // sub
                6:     progImage[i] = encR(7'h00, rs2, rs1, 3'd7, rd);       // and
                7:     progImage[i] = encR(7'h00, rs2, rs1, 3'd6, rd);       // or
                8:     progImage[i] = encR(7'h00, rs2, rs1, 3'd1, rd);       // sll
                9:     progImage[i] = encR(7'h00, rs2, rs1, 3'd2, rd);       // slt
                10:    progImage[i] = encB(13'(off * 4), rs2, rs1, 3'd0);    // beq
                11:    progImage[i] = encB(13'(off * 4), rs2, rs1, 3'd4);    // blt
                12:    progImage[i] = encJ(21'(off * 4), rd);                // jal
                default: begin
                    case (randBits(2))  // encodings the core does not implement
                        0: progImage[i] = encI(imm, rs1, 3'd4, rd, 7'b0010011);  // xori
                        1: progImage[i] = encI(imm, rs1, 3'd2, rd, 7'b0000011);  // lw
                        2: progImage[i] = encB(13'(off * 4), rs2, rs1, 3'd1);    // bne
                        default: progImage[i] = encR(7'h20, rs2, rs1, 3'd7, rd);
                    endcase
                end
            endcase
        end
        progImage[ProgWords] = encJ(21'd0, 5'd0);  // halt loop
    endtask

    // reference interpreter stepping one instruction per call
    task automatic modelStep(output logic [31:0] expPc, output logic [31:0] expRd,
                             output logic [31:0] expValue, output logic taken);
        logic [31:0]           w;
        logic [6:0]            opc;
        logic [6:0]            f7;
        logic [2:0]            f3;
        logic [4:0]            rd;
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic [`CORE_XLEN-1:0] a;
        logic [`CORE_XLEN-1:0] b;
        logic [`CORE_XLEN-1:0] immI;
        logic [`CORE_XLEN-1:0] immB;
        logic [`CORE_XLEN-1:0] immJ;
        logic [`CORE_XLEN-1:0] res;
        logic [`CORE_XLEN-1:0] target;
        logic                  wr;
        w      = progImage[modelPc[31:2]];
        opc    = w[6:0];
        rd     = w[11:7];
        f3     = w[14:12];
        rs1    = w[19:15];
        rs2    = w[24:20];
        f7     = w[31:25];
        a      = modelRegs[rs1];
        b      = modelRegs[rs2];
        immI   = {{20{w[31]}}, w[31:20]};
        immB   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        immJ   = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        res    = '0;
        wr     = 1'b0;
        taken  = 1'b0;
        target = modelPc + immB;
        case (opc)
            7'b0010011: begin
                wr = 1'b1;
                case (f3)
                    3'd0: res = a + immI;
                    3'd2: res = ($signed(a) < $signed(immI)) ? 1 : 0;
                    3'd7: res = a & immI;
                    3'd1: begin
                        res = a << immI[4:0];
                        wr  = (f7 == 7'h00);
                    end
                    default: wr = 1'b0;  // xori and friends
                endcase
            end
            7'b0110011: begin
                wr = 1'b1;
                case ({f7, f3})
                    {7'h00, 3'd0}: res = a + b;
                    {7'h20, 3'd0}: res = a - b;
                    {7'h00, 3'd7}: res = a & b;
                    {7'h00, 3'd6}: res = a | b;
                    {7'h00, 3'd1}: res = a << b[4:0];
                    {7'h00, 3'd2}: res = ($signed(a) < $signed(b)) ? 1 : 0;
                    default:       wr = 1'b0;
                endcase
            end
            7'b1100011: begin
                if (f3 == 3'd0) taken = (a == b);
                if (f3 == 3'd4) taken = ($signed(a) < $signed(b));
            end
            7'b1101111: begin
                wr     = 1'b1;
                res    = modelPc + 4;  // link
                taken  = 1'b1;
                target = modelPc + immJ;
            end
            default: ;  // no-op
        endcase
        expPc = modelPc;
        if (wr && rd != 5'd0) begin
            modelRegs[rd] = res;
            expRd         = rd;
            expValue      = res;
        end else begin
            expRd    = '0;  // x0 writes and no-ops report nothing
            expValue = '0;
        end
        modelPc = taken ? target : modelPc + 4;
    endtask

    task automatic abortRun();
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            abortRun();
        end
    endtask

    // counts falling edges until the next retire strobe
    task automatic waitRetire(output int cycles);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > RetireTimeout) begin
                $display("timeout at %0t: the core stopped retiring", $time);
                abortRun();
            end
        end while (retireValid !== 1'b1);
        cycles = n;
    endtask

    initial begin
        logic [31:0] expPc;
        logic [31:0] expRd;
        logic [31:0] expValue;
        logic        taken;
        int          gap;
        int          expGap;
        int          retired;
        int          haltSeen;
        int          i;
        clk      = 1'b0;
        rstN     = 1'b0;
        prog     = '0;
        lfsr     = 16'd55;  // fixed seed
        modelPc  = '0;
        retired  = 0;
        haltSeen = 0;
        expGap   = 1;
        for (i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        genProgram();

        for (i = 0; i <= ProgWords; i++) begin  // load while reset is low
            @(posedge clk);
            prog <= '{writeEn: 1'b1, addr: i[ImemAddrW-1:0], data: progImage[i]};
        end
        @(posedge clk);
        prog <= '0;
        for (i = 0; i < 16; i++) begin  // then 16 cycles of plain reset
            @(negedge clk);
            checkValue("retireValid", 32'd0, {31'd0, retireValid});
        end
        @(posedge clk);
        rstN <= 1'b1;

        while (haltSeen < 2) begin
            waitRetire(gap);
            modelStep(expPc, expRd, expValue, taken);
            if (retired > 0) begin
                checkValue("retire spacing", expGap, gap);  // 3 after a redirect
            end
            checkValue("retire.pc", expPc, retire.pc);
            checkValue("retire.rd", expRd, {27'd0, retire.rd});
            checkValue("retire.value", expValue, retire.value);
            expGap = taken ? 3 : 1;
            if (expPc == HaltPc) begin
                haltSeen++;
            end
            retired++;
            if (retired > MaxRetires) begin
                $display("the core retired %0d instructions without reaching the halt loop",
                         retired);
                abortRun();
            end
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

/* compile.f */
+incdir+include
hw/isaPkg.sv
hw/pipePkg.sv
hw/instructionMemory.sv
hw/stageReg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/resultStage.sv
hw/riscvCore.sv
verification/tbRiscvCore.sv

/* Bender.yml */
package:
  name: riscvCore

export_include_dirs:
  - include

sources:
  - hw/isaPkg.sv
  - hw/pipePkg.sv
  - hw/instructionMemory.sv
  - hw/stageReg.sv
  - hw/fetchStage.sv
  - hw/decodeStage.sv
  - hw/executeStage.sv
  - hw/resultStage.sv
  - hw/riscvCore.sv
  - target: test
    files:
      - verification/tbRiscvCore.sv
